// ==== exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::word_t   src1_i,
  input  exu_pkg::word_t   src2_i,
  input  exu_pkg::alu_op_e op_i,
  output exu_pkg::word_t   res_o
);

  logic [4:0] shamt;

  // Only the low five bits count for RV32 shifts
  assign shamt = src2_i[4:0];

  always_comb begin
    res_o = '0;
    case (op_i)
      exu_pkg::ALU_ADD: begin
        res_o = src1_i + src2_i;
      end
      exu_pkg::ALU_SUB: begin
        res_o = src1_i - src2_i;
      end
      exu_pkg::ALU_AND: begin
        res_o = src1_i & src2_i;
      end
      exu_pkg::ALU_OR: begin
        res_o = src1_i | src2_i;
      end
      exu_pkg::ALU_XOR: begin
        res_o = src1_i ^ src2_i;
      end
      exu_pkg::ALU_SLL: begin
        res_o = src1_i << shamt;
      end
      exu_pkg::ALU_SRL: begin
        res_o = src1_i >> shamt;
      end
      exu_pkg::ALU_SRA: begin
        res_o = $unsigned($signed(src1_i) >>> shamt);
      end
      exu_pkg::ALU_SLT: begin
        res_o = {31'd0, $signed(src1_i) < $signed(src2_i)};
      end
      exu_pkg::ALU_SLTU: begin
        res_o = {31'd0, src1_i < src2_i};
      end
      // Greater-or-equal forms feed bge and bgeu
      exu_pkg::ALU_SGE: begin
        res_o = {31'd0, $signed(src1_i) >= $signed(src2_i)};
      end
      exu_pkg::ALU_SGEU: begin
        res_o = {31'd0, src1_i >= src2_i};
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

// ==== exu_csr_file.sv ====
`timescale 1ns/1ps

module exu_csr_file #(
  parameter exu_pkg::word_t TRAP_VECTOR = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  exu_pkg::csr_addr_t  addr_i,
  output exu_pkg::word_t      rdata_o,
  input  logic                wen_i,
  input  exu_pkg::word_t      wdata_i,
  input  logic                trap_i,
  input  exu_pkg::word_t      trap_pc_i,
  output exu_pkg::word_t      mepc_o,
  output exu_pkg::word_t      mtvec_o
);

  exu_pkg::word_t mstatus;
  exu_pkg::word_t mtvec;
  exu_pkg::word_t mepc;
  exu_pkg::word_t mcause;

  // Combinational read port
  always_comb begin
    case (addr_i)
      exu_pkg::CSR_MSTATUS: rdata_o = mstatus;
      exu_pkg::CSR_MTVEC:   rdata_o = mtvec;
      exu_pkg::CSR_MEPC:    rdata_o = mepc;
      exu_pkg::CSR_MCAUSE:  rdata_o = mcause;
      default:              rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= TRAP_VECTOR;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wen_i) begin
        case (addr_i)
          exu_pkg::CSR_MSTATUS: mstatus <= wdata_i;
          exu_pkg::CSR_MTVEC:   mtvec   <= wdata_i;
          exu_pkg::CSR_MEPC:    mepc    <= wdata_i;
          exu_pkg::CSR_MCAUSE:  mcause  <= wdata_i;
          default: begin
          end
        endcase
      end
      // Trap port saves the faulting pc
      if (trap_i) begin
        mepc <= trap_pc_i;
      end
    end
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  // The execute stage must never drive both mepc writers at once
  a_no_mepc_conflict: assert property (
    @(posedge clk) disable iff (rst)
    !(trap_i && wen_i && (addr_i == exu_pkg::CSR_MEPC))
  ) else $error("trap and CSR write hit mepc in the same cycle");

endmodule

// ==== exu_execute.sv ====
`timescale 1ns/1ps

module exu_execute #(
  parameter exu_pkg::word_t TRAP_VECTOR = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  input  exu_pkg::exu_issued_t  in_data_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output exu_pkg::exu_result_t  out_result_o,
  input  logic                  out_ready_i
);

  exu_pkg::word_t      alu_res;
  exu_pkg::word_t      pc_plus4;
  exu_pkg::word_t      csr_rdata;
  exu_pkg::word_t      csr_wdata;
  exu_pkg::word_t      mepc;
  exu_pkg::word_t      mtvec;
  exu_pkg::csr_addr_t  csr_addr;
  logic                csr_wr;
  logic                trap;
  logic                fire;
  logic                taken;
  exu_pkg::exu_result_t res_d;
  exu_pkg::exu_result_t res_q;

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign fire       = in_valid_i && in_ready_o;
  assign pc_plus4   = in_data_i.pc + 32'd4;

  exu_alu u_alu (
    .src1_i (in_data_i.src1),
    .src2_i (in_data_i.src2),
    .op_i   (in_data_i.alu_op),
    .res_o  (alu_res)
  );

  // CSR state only changes on an accepted transfer
  exu_csr_file #(
    .TRAP_VECTOR (TRAP_VECTOR)
  ) u_csr_file (
    .clk       (clk),
    .rst       (rst),
    .addr_i    (csr_addr),
    .rdata_o   (csr_rdata),
    .wen_i     (csr_wr && fire),
    .wdata_i   (csr_wdata),
    .trap_i    (trap && fire),
    .trap_pc_i (in_data_i.pc),
    .mepc_o    (mepc),
    .mtvec_o   (mtvec)
  );

  // beq compares through SUB, all other branch ops test for a nonzero result
  assign taken = (in_data_i.alu_op == exu_pkg::ALU_SUB) ? (alu_res == '0) : (alu_res != '0);

  always_comb begin
    res_d.rd      = in_data_i.rd;
    res_d.rd_wen  = in_data_i.rd_wen;
    res_d.rd_data = alu_res;
    res_d.next_pc = pc_plus4;
    res_d.ebreak  = 1'b0;
    csr_addr      = in_data_i.csr_addr;
    csr_wdata     = '0;
    csr_wr        = 1'b0;
    trap          = 1'b0;
    case (in_data_i.op_class)
      exu_pkg::CLASS_JUMP: begin
        res_d.next_pc = in_data_i.target;
        res_d.rd_data = pc_plus4;
      end
      exu_pkg::CLASS_BRANCH: begin
        res_d.rd_wen = 1'b0;
        if (taken) begin
          res_d.next_pc = in_data_i.target;
        end
      end
      exu_pkg::CLASS_SYSTEM: begin
        res_d.rd_data = csr_rdata;
        case (in_data_i.sys_op)
          exu_pkg::SYS_CSRRW: begin
            csr_wr    = 1'b1;
            csr_wdata = in_data_i.src1;
          end
          exu_pkg::SYS_CSRRS: begin
            csr_wr    = 1'b1;
            csr_wdata = csr_rdata | in_data_i.src1;
          end
          exu_pkg::SYS_CSRRC: begin
            csr_wr    = 1'b1;
            csr_wdata = csr_rdata & ~in_data_i.src1;
          end
          exu_pkg::SYS_ECALL: begin
            // mcause through the general port, mepc through the trap port
            csr_addr      = exu_pkg::CSR_MCAUSE;
            csr_wr        = 1'b1;
            csr_wdata     = exu_pkg::CAUSE_ECALL_M;
            trap          = 1'b1;
            res_d.rd_wen  = 1'b0;
            res_d.next_pc = mtvec;
          end
          exu_pkg::SYS_MRET: begin
            // MPIE goes to MIE, MPIE set
            csr_addr      = exu_pkg::CSR_MSTATUS;
            csr_wr        = 1'b1;
            csr_wdata     = {csr_rdata[31:8], 1'b1, csr_rdata[6:4], csr_rdata[7],
                             csr_rdata[2:0]};
            res_d.rd_wen  = 1'b0;
            res_d.next_pc = mepc;
          end
          exu_pkg::SYS_EBREAK: begin
            res_d.rd_wen = 1'b0;
            res_d.ebreak = 1'b1;
          end
          default: begin
            res_d.rd_wen = 1'b0;
          end
        endcase
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o  <= 1'b0;
      res_q.ebreak <= 1'b0;
    end else if (fire) begin
      out_valid_o <= 1'b1;
      res_q       <= res_d;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  assign out_result_o = res_q;

  a_valid_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(out_valid_o)
  ) else $error("result valid is unknown");

endmodule

// ==== exu_issue_reg.sv ====
`timescale 1ns/1ps

module exu_issue_reg (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  input  exu_pkg::exu_uop_t     in_uop_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output exu_pkg::exu_issued_t  out_data_o,
  input  logic                  out_ready_i
);

  exu_pkg::exu_issued_t issued_d;
  logic                 load;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_comb begin
    issued_d.op_class = in_uop_i.op_class;
    issued_d.alu_op   = in_uop_i.alu_op;
    issued_d.sys_op   = in_uop_i.sys_op;
    issued_d.rd       = in_uop_i.rd;
    issued_d.rd_wen   = in_uop_i.rd_wen;
    issued_d.csr_addr = in_uop_i.csr_addr;
    issued_d.pc       = in_uop_i.pc;
    issued_d.src1     = in_uop_i.src1;
    issued_d.src2     = in_uop_i.src2;
    // jal uses pc as base, jalr uses rs1
    issued_d.target   = in_uop_i.base + in_uop_i.imm;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data_o <= issued_d;
    end
  end

  a_hold_while_stalled: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=> $stable(out_data_o)
  ) else $error("issued micro-op changed while stalled");

endmodule

// ==== exu_pkg.sv ====
package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_SGE  = 4'd10,
    ALU_SGEU = 4'd11
  } alu_op_e;

  typedef enum logic [1:0] {
    CLASS_ALU    = 2'd0,
    CLASS_JUMP   = 2'd1,
    CLASS_BRANCH = 2'd2,
    CLASS_SYSTEM = 2'd3
  } op_class_e;

  typedef enum logic [2:0] {
    SYS_CSRRW  = 3'd0,
    SYS_CSRRS  = 3'd1,
    SYS_CSRRC  = 3'd2,
    SYS_ECALL  = 3'd3,
    SYS_MRET   = 3'd4,
    SYS_EBREAK = 3'd5
  } sys_op_e;

  // Machine CSR addresses
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam word_t CAUSE_ECALL_M = 32'd11;

  // Immediate CSR forms carry the zero-extended immediate in src1
  typedef struct packed {
    op_class_e op_class;
    alu_op_e   alu_op;
    sys_op_e   sys_op;
    reg_idx_t  rd;
    logic      rd_wen;
    csr_addr_t csr_addr;
    word_t     pc;
    word_t     src1;
    word_t     src2;
    word_t     base;
    word_t     imm;
  } exu_uop_t;

  typedef struct packed {
    op_class_e op_class;
    alu_op_e   alu_op;
    sys_op_e   sys_op;
    reg_idx_t  rd;
    logic      rd_wen;
    csr_addr_t csr_addr;
    word_t     pc;
    word_t     src1;
    word_t     src2;
    word_t     target;
  } exu_issued_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     rd_wen;
    word_t    rd_data;
    word_t    next_pc;
    logic     ebreak;
  } exu_result_t;

endpackage

// ==== exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb;

  // About 650 micro-ops; with stalls the stimulus runs under 2000 cycles
  localparam int TIMEOUT_CYCLES = 6000;

  logic                 clk;
  logic                 rst;
  logic                 in_valid_i;
  exu_pkg::exu_uop_t    in_uop_i;
  logic                 in_ready_o;
  logic                 out_valid_o;
  exu_pkg::exu_result_t out_result_o;
  logic                 out_ready_i;

  exu_pkg::exu_result_t exp_q[$];
  exu_pkg::exu_result_t head;
  logic                 has_head;
  exu_pkg::word_t       m_mstatus;
  exu_pkg::word_t       m_mtvec;
  exu_pkg::word_t       m_mepc;
  exu_pkg::word_t       m_mcause;
  int                   errors;
  int                   checked;
  int                   cycles;
  int                   tests_passed;
  int                   tests_failed;
  int                   mark_errors;
  int                   mark_checked;

  exu_top u_exu_top (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .in_uop_i     (in_uop_i),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_ready_i  (out_ready_i)
  );

  always #20 clk = ~clk;

  // Sink accepts about 70% of the time
  always @(posedge clk) begin
    out_ready_i <= ($urandom_range(99) >= 30);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic exu_pkg::word_t alu_ref(exu_pkg::alu_op_e op, exu_pkg::word_t a,
                                             exu_pkg::word_t b);
    case (op)
      exu_pkg::ALU_ADD:  return a + b;
      exu_pkg::ALU_SUB:  return a - b;
      exu_pkg::ALU_AND:  return a & b;
      exu_pkg::ALU_OR:   return a | b;
      exu_pkg::ALU_XOR:  return a ^ b;
      exu_pkg::ALU_SLL:  return a << b[4:0];
      exu_pkg::ALU_SRL:  return a >> b[4:0];
      exu_pkg::ALU_SRA:  return exu_pkg::word_t'($signed(a) >>> b[4:0]);
      exu_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SGE:  return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SGEU: return (a >= b) ? 32'd1 : 32'd0;
      default:           return '0;
    endcase
  endfunction

  function automatic exu_pkg::word_t csr_peek(exu_pkg::csr_addr_t a);
    case (a)
      exu_pkg::CSR_MSTATUS: return m_mstatus;
      exu_pkg::CSR_MTVEC:   return m_mtvec;
      exu_pkg::CSR_MEPC:    return m_mepc;
      exu_pkg::CSR_MCAUSE:  return m_mcause;
      default:              return '0;
    endcase
  endfunction

  function automatic void csr_poke(exu_pkg::csr_addr_t a, exu_pkg::word_t v);
    case (a)
      exu_pkg::CSR_MSTATUS: m_mstatus = v;
      exu_pkg::CSR_MTVEC:   m_mtvec = v;
      exu_pkg::CSR_MEPC:    m_mepc = v;
      exu_pkg::CSR_MCAUSE:  m_mcause = v;
      default: begin
      end
    endcase
  endfunction

  function automatic exu_pkg::exu_result_t predict(exu_pkg::exu_uop_t u);
    exu_pkg::exu_result_t r;
    exu_pkg::word_t       old;
    logic                 taken;
    r.rd      = u.rd;
    r.rd_wen  = u.rd_wen;
    r.rd_data = alu_ref(u.alu_op, u.src1, u.src2);
    r.next_pc = u.pc + 32'd4;
    r.ebreak  = 1'b0;
    old       = csr_peek(u.csr_addr);
    taken     = (u.alu_op == exu_pkg::ALU_SUB) ? (u.src1 == u.src2) : (r.rd_data != '0);
    if (u.op_class == exu_pkg::CLASS_JUMP) begin
      r.next_pc = u.base + u.imm;
      r.rd_data = u.pc + 32'd4;
    end else if (u.op_class == exu_pkg::CLASS_BRANCH) begin
      r.rd_wen = 1'b0;
      if (taken) begin
        r.next_pc = u.base + u.imm;
      end
    end else if (u.op_class == exu_pkg::CLASS_SYSTEM) begin
      r.rd_data = old;
      case (u.sys_op)
        exu_pkg::SYS_CSRRW: csr_poke(u.csr_addr, u.src1);
        exu_pkg::SYS_CSRRS: csr_poke(u.csr_addr, old | u.src1);
        exu_pkg::SYS_CSRRC: csr_poke(u.csr_addr, old & ~u.src1);
        exu_pkg::SYS_ECALL: begin
          m_mcause  = exu_pkg::CAUSE_ECALL_M;
          m_mepc    = u.pc;
          r.next_pc = m_mtvec;
        end
        exu_pkg::SYS_MRET: begin
          r.next_pc    = m_mepc;
          m_mstatus[3] = m_mstatus[7];
          m_mstatus[7] = 1'b1;
        end
        default: r.ebreak = (u.sys_op == exu_pkg::SYS_EBREAK);
      endcase
      if (u.sys_op inside {exu_pkg::SYS_ECALL, exu_pkg::SYS_MRET, exu_pkg::SYS_EBREAK}) begin
        r.rd_wen = 1'b0;
      end
    end
    return r;
  endfunction

  function automatic exu_pkg::exu_uop_t alu_uop();
    exu_pkg::exu_uop_t u;
    u          = '0;
    u.op_class = exu_pkg::CLASS_ALU;
    u.alu_op   = exu_pkg::alu_op_e'(4'($urandom_range(11)));
    u.rd       = 5'($urandom_range(31));
    u.rd_wen   = 1'($urandom_range(1));
    u.pc       = $urandom & 32'hffff_fffc;
    u.src1     = $urandom;
    u.src2     = $urandom;
    u.base     = $urandom;
    u.imm      = $urandom;
    return u;
  endfunction

  // Cycles through beq, bne, blt, bltu, bge, bgeu and a jump
  function automatic exu_pkg::exu_uop_t flow_uop(int i);
    exu_pkg::exu_uop_t u;
    u = alu_uop();
    case (i % 7)
      0: u.alu_op = exu_pkg::ALU_SUB;
      1: u.alu_op = exu_pkg::ALU_XOR;
      2: u.alu_op = exu_pkg::ALU_SLT;
      3: u.alu_op = exu_pkg::ALU_SLTU;
      4: u.alu_op = exu_pkg::ALU_SGE;
      default: u.alu_op = exu_pkg::ALU_SGEU;
    endcase
    u.op_class = (i % 7 == 6) ? exu_pkg::CLASS_JUMP : exu_pkg::CLASS_BRANCH;
    if ((i / 7) % 2 == 0) begin
      u.src2 = u.src1;
    end
    return u;
  endfunction

  function automatic exu_pkg::exu_uop_t sys_uop(exu_pkg::sys_op_e op, exu_pkg::csr_addr_t a,
                                                exu_pkg::word_t v);
    exu_pkg::exu_uop_t u;
    u          = alu_uop();
    u.op_class = exu_pkg::CLASS_SYSTEM;
    u.sys_op   = op;
    u.csr_addr = a;
    u.src1     = v;
    u.rd_wen   = 1'b1;
    return u;
  endfunction

  function automatic exu_pkg::exu_uop_t mixed_uop();
    exu_pkg::exu_uop_t  u;
    exu_pkg::csr_addr_t a;
    int unsigned        pick;
    pick = $urandom_range(9);
    a    = ($urandom_range(1) == 0) ? exu_pkg::CSR_MSTATUS : exu_pkg::CSR_MEPC;
    u    = alu_uop();
    if (pick inside {[4:5]}) begin
      u = flow_uop($urandom_range(13));
    end else if (pick == 6) begin
      u = sys_uop(exu_pkg::sys_op_e'(3'($urandom_range(2))), a, $urandom);
    end else if (pick >= 7) begin
      u = sys_uop((pick == 7) ? exu_pkg::SYS_EBREAK :
                  (pick == 8) ? exu_pkg::SYS_ECALL : exu_pkg::SYS_MRET, '0, '0);
    end
    return u;
  endfunction

  // Expected results in acceptance order, head sampled by the checks
  always @(posedge clk) begin
    if (rst) begin
      m_mstatus = '0;
      m_mtvec   = 32'h8000_0100;
      m_mepc    = '0;
      m_mcause  = '0;
      has_head <= 1'b0;
    end else begin
      if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        checked++;
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(predict(in_uop_i));
      end
      has_head <= (exp_q.size() != 0);
      if (exp_q.size() != 0) begin
        head <= exp_q[0];
      end
    end
  end

  a_next_pc: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i && has_head) |-> (out_result_o.next_pc == head.next_pc))
  else begin
    $display("FAIL %0t: next_pc differs from the expected value", $time);
    errors++;
  end

  a_write: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i && has_head) |-> (out_result_o.rd_wen == head.rd_wen &&
      (!head.rd_wen || (out_result_o.rd == head.rd && out_result_o.rd_data == head.rd_data))))
  else begin
    $display("FAIL %0t: register write differs from the expected value", $time);
    errors++;
  end

  a_ebreak: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i && has_head) |->
      (out_result_o.ebreak == head.ebreak && !(out_result_o.ebreak && out_result_o.rd_wen)))
  else begin
    $display("FAIL %0t: ebreak flag or its write enable is wrong", $time);
    errors++;
  end

  a_orphan: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i) |-> has_head)
  else begin
    $display("A result came out at %0t with no accepted micro-op waiting for it", $time);
    errors++;
  end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_result_o)))
  else begin
    $display("FAIL %0t: stalled result changed or was dropped", $time);
    errors++;
  end

  // Input side may only block when both stages hold a micro-op
  a_ready: assert property (@(posedge clk) disable iff (rst)
    !in_ready_o |-> (u_exu_top.iss_valid && out_valid_o && !out_ready_i))
  else begin
    $display("The input side refused a micro-op at %0t while a stage had room", $time);
    errors++;
  end

  a_reset: assert property (@(posedge clk)
    $fell(rst) |-> (in_ready_o && !out_valid_o && !out_result_o.ebreak))
  else begin
    $display("FAIL %0t: outputs not at their reset values", $time);
    errors++;
  end

  task automatic send(exu_pkg::exu_uop_t u);
    in_uop_i   <= u;
    in_valid_i <= 1'b1;
    @(posedge clk);
    while (!in_ready_o) begin
      @(posedge clk);
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic close_test(string name);
    do begin
      @(posedge clk);
    end while (exp_q.size() != 0);
    @(posedge clk);
    if (errors == mark_errors) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("%0t test %s: %0d results, %0d errors", $time, name, checked - mark_checked,
             errors - mark_errors);
    mark_errors  = errors;
    mark_checked = checked;
  endtask

  initial begin
    exu_pkg::csr_addr_t a;
    void'($urandom(10351));
    clk         = 1'b0;
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    in_uop_i    = '0;
    out_ready_i = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 300; i++) send(alu_uop());
    close_test("alu_random");

    for (int i = 0; i < 84; i++) send(flow_uop(i));
    close_test("jump_branch");

    for (int i = 0; i < 6; i++) begin
      a = (i % 2 == 0) ? exu_pkg::CSR_MTVEC : exu_pkg::CSR_MEPC;
      send(sys_uop(exu_pkg::SYS_CSRRW, a, $urandom));
      send(sys_uop(exu_pkg::SYS_CSRRS, a, $urandom));
      send(sys_uop(exu_pkg::SYS_CSRRC, a, $urandom));
      send(sys_uop(exu_pkg::SYS_CSRRS, a, '0));
    end
    close_test("csr_rw_set_clear");

    send(sys_uop(exu_pkg::SYS_CSRRW, exu_pkg::CSR_MTVEC, 32'h0000_4000));
    for (int i = 0; i < 4; i++) begin
      send(sys_uop(exu_pkg::SYS_CSRRW, exu_pkg::CSR_MSTATUS, $urandom));
      send(sys_uop(exu_pkg::SYS_ECALL, '0, '0));
      send(sys_uop(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MEPC, '0));
      send(sys_uop(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MCAUSE, '0));
      send(sys_uop(exu_pkg::SYS_MRET, '0, '0));
      send(sys_uop(exu_pkg::SYS_CSRRS, exu_pkg::CSR_MSTATUS, '0));
    end
    close_test("ecall_mret");

    for (int i = 0; i < 8; i++) begin
      send(sys_uop(exu_pkg::SYS_EBREAK, '0, '0));
      send(alu_uop());
    end
    close_test("ebreak");

    for (int i = 0; i < 200; i++) send(mixed_uop());
    close_test("mixed_backpressure");

    $display("tests passed %0d, tests failed %0d, results checked %0d, check errors %0d",
             tests_passed, tests_failed, checked, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== exu_top.sv ====
`timescale 1ns/1ps

module exu_top #(
  parameter exu_pkg::word_t TRAP_VECTOR = 32'h8000_0100
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  input  exu_pkg::exu_uop_t     in_uop_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output exu_pkg::exu_result_t  out_result_o,
  input  logic                  out_ready_i
);

  logic                 iss_valid;
  logic                 iss_ready;
  exu_pkg::exu_issued_t iss_data;

  exu_issue_reg u_issue_reg (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_uop_i    (in_uop_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (iss_valid),
    .out_data_o  (iss_data),
    .out_ready_i (iss_ready)
  );

  exu_execute #(
    .TRAP_VECTOR (TRAP_VECTOR)
  ) u_execute (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (iss_valid),
    .in_data_i    (iss_data),
    .in_ready_o   (iss_ready),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module exu_tb -f verilog.f -o exu_sim \
  && ./obj_dir/exu_sim | tee sim.log \
  || { echo "Build or simulation run did not complete"; exit 1; }
grep -q "Verification failed" sim.log \
  && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }

// ==== verilog.f ====
exu_pkg.sv
exu_alu.sv
exu_csr_file.sv
exu_issue_reg.sv
exu_execute.sv
exu_top.sv
exu_tb.sv
